// File: Bender.yml
package:
  name: operator_slot_controller

export_include_dirs:
  - source

sources:
  - source/opl3_reg_pkg.sv
  - source/opl3_slot_pkg.sv
  - source/channel_reg_file.sv
  - source/operator_scheduler.sv
  - source/connection_router.sv
  - source/operator_result_ram.sv
  - source/operator_slot_controller.sv
  - target: test
    files:
      - test/operator_slot_controller_props.sv
      - test/operator_slot_controller_tb.sv

// File: operator_slot_controller.f
+incdir+source
source/opl3_reg_pkg.sv
source/opl3_slot_pkg.sv
source/channel_reg_file.sv
source/operator_scheduler.sv
source/connection_router.sv
source/operator_result_ram.sv
source/operator_slot_controller.sv
test/operator_slot_controller_props.sv
test/operator_slot_controller_tb.sv

// File: source/channel_reg_file.sv
// Channel register file.
// Holds the registers of all 18 channels, written one channel per
// cycle by the host. One full read for the channel in use, and a
// cnt-only read for the partner channel of a 4-operator pair.

`timescale 1ns/100ps
`default_nettype none
`include "opl3_consts.svh"

module channel_reg_file
    import opl3_reg_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  chan_write_t   chan_write,
    input  chan_addr_t    rd_chan,
    output channel_regs_t regs,
    input  chan_addr_t    pair_chan,
    output logic          pair_cnt
);

    localparam logic [3:0] NUM_CHANS = 4'(`NUM_CHANS_PER_BANK);

    channel_regs_t chan_q [`NUM_BANKS][`NUM_CHANS_PER_BANK];

    logic wr_ok;
    logic rd_ok;
    logic pair_ok;

    assign wr_ok   = chan_write.valid && (chan_write.addr.channel < NUM_CHANS);
    assign rd_ok   = rd_chan.channel < NUM_CHANS;   // channels 9..15 unmapped
    assign pair_ok = pair_chan.channel < NUM_CHANS;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < `NUM_BANKS; b++) begin
                for (int c = 0; c < `NUM_CHANS_PER_BANK; c++) begin
                    chan_q[b][c] <= '0;
                end
            end
        end else if (wr_ok) begin
            chan_q[chan_write.addr.bank][chan_write.addr.channel] <= chan_write.regs;
        end
    end

    assign regs     = rd_ok ? chan_q[rd_chan.bank][rd_chan.channel] : '0;
    assign pair_cnt = pair_ok ? chan_q[pair_chan.bank][pair_chan.channel].cnt : 1'b0;

endmodule
`default_nettype wire

// File: source/connection_router.sv
// Connection router.
// Maps the current slot to its channel and operator role. Operators
// pair up as o and o+3 within a group of six. With a 4-operator enable
// set, slots 6..11 of the bank extend channel k (k = 0..2) and the
// roles follow the cnt bits of channels k and k+3 together.

`timescale 1ns/100ps
`default_nettype none
`include "opl3_consts.svh"

module connection_router
    import opl3_reg_pkg::*;
    import opl3_slot_pkg::*;
(
    input  slot_addr_t    cur_slot,
    input  conn_sel_t     conn_sel,
    input  channel_regs_t regs,
    output chan_addr_t    rd_chan,
    output chan_addr_t    pair_chan,
    input  logic          pair_cnt,
    output mod_route_t    route,
    output op_request_t   op_request
);

    localparam int OP_W = $bits(cur_slot.op);

    logic [1:0]      grp;       // group of six operators
    logic [1:0]      lane;      // position within the channel triple
    logic            second;    // carrier half of the pair
    logic [2:0]      sel_bit;
    logic            four_op;
    logic [3:0]      chan_num;
    op_role_e        role;
    logic [OP_W-1:0] src_op;

    always_comb begin
        grp     = 2'(cur_slot.op / OP_W'(6));
        lane    = 2'(cur_slot.op % OP_W'(3));
        second  = (cur_slot.op % OP_W'(6)) >= OP_W'(3);
        sel_bit = {1'b0, lane} + (cur_slot.bank ? 3'd3 : 3'd0);
        four_op = (grp == 2'd1) && conn_sel[sel_bit];

        // 4-op pairs take fnum, block and kon from the low channel
        chan_num  = four_op ? {2'b00, lane} : ({2'b00, grp} * 4'd3 + {2'b00, lane});
        rd_chan   = '{bank: cur_slot.bank, channel: chan_num};
        pair_chan = '{bank: cur_slot.bank, channel: {2'b00, lane} + 4'd3};
    end

    // source is always three operators back when there is one
    assign src_op = cur_slot.op - OP_W'(3);

    always_comb begin
        if (four_op) begin
            if (!second) begin
                // third operator of the chain, fed by op 3+k
                role = (!regs.cnt && pair_cnt) ? ROLE_PARALLEL : ROLE_MODULATED;
            end else begin
                // last operator, fed by op 6+k
                role = (regs.cnt && pair_cnt) ? ROLE_PARALLEL : ROLE_MODULATED;
            end
        end else if (!second) begin
            role = ROLE_FEEDBACK;
        end else begin
            role = regs.cnt ? ROLE_PARALLEL : ROLE_MODULATED;
        end
    end

    always_comb begin
        route.role    = role;
        route.channel = rd_chan;
        if (role == ROLE_FEEDBACK) begin
            route.source = cur_slot;   // no source, points at itself
        end else begin
            route.source = '{bank: cur_slot.bank, op: src_op};
        end
    end

    always_comb begin
        op_request.slot         = cur_slot;
        op_request.fnum         = regs.fnum;
        op_request.block        = regs.block;
        op_request.kon          = regs.kon;
        op_request.use_feedback = (role == ROLE_FEEDBACK);
        op_request.fb           = (role == ROLE_FEEDBACK) ? regs.fb : '0;
        op_request.modulation   = '0;  // filled in at the top level
    end

endmodule
`default_nettype wire

// File: source/operator_result_ram.sv
// Operator result memory.
// One entry per slot. Written with the operator output on the capture
// strobe, read back combinationally for modulation and by the host.

`timescale 1ns/100ps
`default_nettype none
`include "opl3_consts.svh"

module operator_result_ram
    import opl3_slot_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            op_capture,
    input  slot_addr_t                      cur_slot,
    input  logic signed [`OP_OUT_WIDTH-1:0] op_result,
    input  slot_addr_t                      mod_slot,
    output logic signed [`OP_OUT_WIDTH-1:0] mod_value,
    input  slot_addr_t                      host_slot,
    output logic signed [`OP_OUT_WIDTH-1:0] host_value
);

    localparam int IDX_W = $clog2(`NUM_SLOTS);

    logic signed [`OP_OUT_WIDTH-1:0] mem [`NUM_SLOTS];

    // flat index, bank 1 follows bank 0
    function automatic logic [IDX_W-1:0] slot_index(input slot_addr_t s);
        return s.bank ? IDX_W'(s.op) + IDX_W'(`NUM_OPS_PER_BANK) : IDX_W'(s.op);
    endfunction

    function automatic logic slot_valid(input slot_addr_t s);
        return s.op < $bits(s.op)'(`NUM_OPS_PER_BANK);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                mem[i] <= '0;
            end
        end else if (op_capture && slot_valid(cur_slot)) begin
            mem[slot_index(cur_slot)] <= op_result;
        end
    end

    assign mod_value  = slot_valid(mod_slot) ? mem[slot_index(mod_slot)] : '0;
    assign host_value = slot_valid(host_slot) ? mem[slot_index(host_slot)] : '0;

endmodule
`default_nettype wire

// File: source/operator_scheduler.sv
// Slot scheduler.
// After a sample tick it walks all 36 operator slots, bank 0 first,
// giving each a fixed window. op_start marks the first cycle of a
// window, op_capture the last. sweep_done pulses on return to idle.

`timescale 1ns/100ps
`default_nettype none
`include "opl3_consts.svh"

module operator_scheduler
    import opl3_slot_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       sample_tick,
    output slot_addr_t cur_slot,
    output logic       op_start,
    output logic       op_capture,
    output logic       sweep_done
);

    localparam int CNT_W = $clog2(`SLOT_CYCLES);
    localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`SLOT_CYCLES - 1);
    localparam logic [$bits(cur_slot.op)-1:0] LAST_OP =
        $bits(cur_slot.op)'(`NUM_OPS_PER_BANK - 1);

    sched_state_e     state;
    slot_addr_t       slot_q;
    logic [CNT_W-1:0] win_cnt; // position inside the slot window
    logic             last_slot;

    assign last_slot  = slot_q.bank && (slot_q.op == LAST_OP);
    assign op_start   = (state == SWEEP) && (win_cnt == '0);
    assign op_capture = (state == SWEEP) && (win_cnt == LAST_CYCLE);
    assign cur_slot   = slot_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            slot_q     <= '0;
            win_cnt    <= '0;
            sweep_done <= 1'b0;
        end else begin
            sweep_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (sample_tick) begin
                        state   <= SWEEP;
                        slot_q  <= '0;
                        win_cnt <= '0;
                    end
                end
                SWEEP: begin
                    if (win_cnt == LAST_CYCLE) begin
                        win_cnt <= '0;
                        if (last_slot) begin
                            state      <= IDLE;
                            slot_q     <= '0;
                            sweep_done <= 1'b1;
                        end else if (slot_q.op == LAST_OP) begin
                            slot_q.bank <= 1'b1;   // bank 0 done, move on
                            slot_q.op   <= '0;
                        end else begin
                            slot_q.op <= slot_q.op + 1'b1;
                        end
                    end else begin
                        win_cnt <= win_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule
`default_nettype wire

// File: source/operator_slot_controller.sv
// FM operator slot controller, top level.
// Sequences the 36 operator slots through one external operator,
// routing channel registers and modulation per slot and keeping
// every operator result for the next slots and the host.

`timescale 1ns/100ps
`default_nettype none
`include "opl3_consts.svh"

module operator_slot_controller
    import opl3_reg_pkg::*;
    import opl3_slot_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            sample_tick,
    input  chan_write_t                     chan_write,
    input  conn_sel_t                       conn_sel,
    output logic                            op_start,
    output op_request_t                     op_request,
    input  logic signed [`OP_OUT_WIDTH-1:0] op_result,
    input  slot_addr_t                      host_slot,
    output logic signed [`OP_OUT_WIDTH-1:0] host_value,
    output logic                            sweep_done
);

    slot_addr_t                      cur_slot;
    logic                            op_capture;
    chan_addr_t                      rd_chan;
    chan_addr_t                      pair_chan;
    channel_regs_t                   regs;
    logic                            pair_cnt;
    mod_route_t                      route;
    op_request_t                     base_request;
    logic signed [`OP_OUT_WIDTH-1:0] mod_value;

    operator_scheduler u_scheduler (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .cur_slot    (cur_slot),
        .op_start    (op_start),
        .op_capture  (op_capture),
        .sweep_done  (sweep_done)
    );

    channel_reg_file u_regs (
        .clk        (clk),
        .reset      (reset),
        .chan_write (chan_write),
        .rd_chan    (rd_chan),
        .regs       (regs),
        .pair_chan  (pair_chan),
        .pair_cnt   (pair_cnt)
    );

    connection_router u_router (
        .cur_slot   (cur_slot),
        .conn_sel   (conn_sel),
        .regs       (regs),
        .rd_chan    (rd_chan),
        .pair_chan  (pair_chan),
        .pair_cnt   (pair_cnt),
        .route      (route),
        .op_request (base_request)
    );

    operator_result_ram u_results (
        .clk        (clk),
        .reset      (reset),
        .op_capture (op_capture),
        .cur_slot   (cur_slot),
        .op_result  (op_result),
        .mod_slot   (route.source),
        .mod_value  (mod_value),
        .host_slot  (host_slot),
        .host_value (host_value)
    );

    // modulation only reaches the operator for modulated roles
    always_comb begin
        op_request            = base_request;
        op_request.modulation = (route.role == ROLE_MODULATED) ? mod_value : '0;
    end

endmodule
`default_nettype wire

// File: source/opl3_consts.svh
// Chip constants for the FM operator slot sequencer.
// Counts, field widths and the per-slot window length.

`ifndef OPL3_CONSTS_SVH
`define OPL3_CONSTS_SVH

`define NUM_BANKS           2
`define NUM_OPS_PER_BANK    18
`define NUM_CHANS_PER_BANK  9
`define NUM_SLOTS           36
`define SLOT_CYCLES         7   // cycles per operator slot

`define FNUM_WIDTH          10
`define BLOCK_WIDTH         3
`define FB_WIDTH            3
`define OP_OUT_WIDTH        13
`define CONN_SEL_WIDTH      6   // one 4-op enable per channel pair

`endif

// File: source/opl3_reg_pkg.sv
// Channel register types.
// Describes the per-channel register set, its address and the host
// write port, plus the 4-operator connection enables.

`include "opl3_consts.svh"

package opl3_reg_pkg;

    typedef struct packed {
        logic [`FNUM_WIDTH-1:0]  fnum;  // frequency number
        logic [`BLOCK_WIDTH-1:0] block; // octave
        logic                    kon;   // key on
        logic [`FB_WIDTH-1:0]    fb;    // feedback depth
        logic                    cnt;   // connection, 1 = parallel
    } channel_regs_t;

    typedef struct packed {
        logic       bank;
        logic [3:0] channel;
    } chan_addr_t;

    typedef struct packed {
        logic          valid;
        chan_addr_t    addr;
        channel_regs_t regs;
    } chan_write_t;

    // bit 3*bank+k joins channel k with channel k+3
    typedef logic [`CONN_SEL_WIDTH-1:0] conn_sel_t;

endpackage

// File: source/opl3_slot_pkg.sv
// Operator slot types.
// Slot addresses, operator roles, sweep states, the request handed
// to the shared operator and the modulation route of a slot.

`include "opl3_consts.svh"

package opl3_slot_pkg;

    import opl3_reg_pkg::*;

    typedef struct packed {
        logic                                  bank;
        logic [$clog2(`NUM_OPS_PER_BANK)-1:0] op;
    } slot_addr_t;

    typedef enum logic [1:0] {
        ROLE_FEEDBACK  = 2'd0, // first operator, self feedback
        ROLE_MODULATED = 2'd1, // phase modulated by source slot
        ROLE_PARALLEL  = 2'd2  // no modulation, no feedback
    } op_role_e;

    typedef enum logic {
        IDLE  = 1'b0,
        SWEEP = 1'b1
    } sched_state_e;

    typedef struct packed {
        slot_addr_t                      slot;
        logic [`FNUM_WIDTH-1:0]          fnum;
        logic [`BLOCK_WIDTH-1:0]         block;
        logic                            kon;
        logic [`FB_WIDTH-1:0]            fb;
        logic                            use_feedback;
        logic signed [`OP_OUT_WIDTH-1:0] modulation;
    } op_request_t;

    typedef struct packed {
        op_role_e   role;
        slot_addr_t source;  // slot whose result modulates this one
        chan_addr_t channel; // channel the slot takes its registers from
    } mod_route_t;

endpackage

// File: test/operator_slot_controller_golden.txt
// test count, then per test: header (write count << 8 | conn_sel), writes, 36 slot words
// write: bank, channel, fnum(3 digits), block, kon, fb, cnt
// slot: role, chan bank, chan, src bank, src op(2 digits), fnum(3 digits), block, kon, fb
2
// two-operator mode, mixed cnt
0500
001a54150 012b03121 040f36071 123c11130 181557161
0000001a5415 0010012b0312 002002000000 1000001a5410 2010012b0310 102002000000
003006000000 0040070f3607 005008000000 103006000000 2040070f3600 105008000000
00600c000000 00700d000000 00800e000000 10600c000000 10700d000000 10800e000000
010100000000 011101000000 0121023c1113 110100000000 111101000000 1121023c1110
013106000000 014107000000 015108000000 113106000000 114107000000 115108000000
01610c000000 01710d000000 01810e155716 11610c000000 11710d000000 21810e155710
// four-operator pairs in both banks, every cnt combination
0a3f
001011110 012022120 023033131 030aa5040 040bb6051 050cc7060
101112171 123335130 130dd4111 150ee1151
000000101111 001001202212 002002303313 100000101110 101001202210 202002303310
100003101110 201004202210 102005303310 100006101110 101007202210 102008303310
00600c000000 00700d000000 00800e000000 10600c000000 10700d000000 10800e000000
010100111217 011101000000 012102333513 210100111210 111101000000 112102333510
110103111210 111104000000 212105333510 210106111210 111107000000 112108333510
01610c000000 01710d000000 01810e000000 11610c000000 11710d000000 11810e000000

// File: test/operator_slot_controller_props.sv
// Timing properties of the slot scheduler, bound into the scheduler.
// Start and capture strobes of a window, and the done pulse.

`timescale 1ns/100ps
`include "opl3_consts.svh"

module operator_slot_controller_props (
    input logic clk,
    input logic reset,
    input logic op_start,
    input logic op_capture,
    input logic sweep_done
);

    int fail_count = 0;   // read by the testbench at the end

    a_strobes_apart: assert property (@(posedge clk) disable iff (reset)
        !(op_start && op_capture))
        else begin
            fail_count++;
            $error("op_start and op_capture high in the same cycle");
        end

    // capture closes the window opened by start
    a_capture_follows: assert property (@(posedge clk) disable iff (reset)
        op_start |-> (!op_capture) [*(`SLOT_CYCLES - 1)] ##1 op_capture)
        else begin
            fail_count++;
            $error("op_capture not %0d cycles after op_start", `SLOT_CYCLES - 1);
        end

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        sweep_done |=> !sweep_done)
        else begin
            fail_count++;
            $error("sweep_done longer than one cycle");
        end

endmodule

bind operator_scheduler operator_slot_controller_props u_props (
    .clk        (clk),
    .reset      (reset),
    .op_start   (op_start),
    .op_capture (op_capture),
    .sweep_done (sweep_done)
);

// File: test/operator_slot_controller_tb.sv
// Testbench for the FM operator slot controller.
// Replays the golden register setups, stands in for the shared operator
// with an LFSR model, and checks requests, routing, timing and readback.

`timescale 1ns/100ps
`include "opl3_consts.svh"

module operator_slot_controller_tb
    import opl3_reg_pkg::*;
    import opl3_slot_pkg::*;
();

    localparam int CLK_HALF        = 4;
    localparam int DRIVE_DELAY     = 1;
    localparam int CYCLES_PER_TEST = 300;

    logic                            clk;
    logic                            reset;
    logic                            sample_tick;
    chan_write_t                     chan_write;
    conn_sel_t                       conn_sel;
    logic                            op_start;
    op_request_t                     op_request;
    logic signed [`OP_OUT_WIDTH-1:0] op_result;
    slot_addr_t                      host_slot;
    logic signed [`OP_OUT_WIDTH-1:0] host_value;
    logic                            sweep_done;

    logic [47:0]                     golden [0:255];
    logic signed [`OP_OUT_WIDTH-1:0] model_out [`NUM_SLOTS]; // operator model output per slot
    logic [31:0]                     lfsr_state;
    int num_tests = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int checks = 0;
    int errors = 0;
    int prev_errors = 0;

    operator_slot_controller dut (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check_request(input string what, input op_request_t got,
                                 input op_request_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input string what, input logic signed [`OP_OUT_WIDTH-1:0] got,
                                input logic signed [`OP_OUT_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_result(output logic signed [`OP_OUT_WIDTH-1:0] value);
        for (int i = 0; i < `OP_OUT_WIDTH; i++) begin
            value[i] = lfsr_state[0];   // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic slot_addr_t slot_of(input int s);
        slot_addr_t a;
        a.bank = (s >= `NUM_OPS_PER_BANK);
        a.op   = 5'(s % `NUM_OPS_PER_BANK);
        return a;
    endfunction

    function automatic chan_write_t write_of(input logic [47:0] w);
        chan_write_t c;
        c.valid = 1'b1;
        c.addr  = '{bank: w[32], channel: w[31:28]};
        c.regs  = '{fnum: w[25:16], block: w[14:12], kon: w[8], fb: w[6:4], cnt: w[0]};
        return c;
    endfunction

    task automatic drive_edge();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic apply_reset();
        drive_edge();
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
    endtask

    task automatic read_back();
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            drive_edge();
            host_slot = slot_of(s);
            @(negedge clk);
            check_result("host readback", host_value, model_out[s]);
            check_flag("op_start while idle", op_start, 1'b0);
        end
    endtask

    // one sweep with a stray tick injected partway; base points at slot 0 of the golden rows
    task automatic run_sweep(input int base);
        int starts;
        int cycle;
        int first_start;
        int last_start;
        int src;
        logic [47:0] g;
        logic done;
        logic tick_sent;
        logic signed [`OP_OUT_WIDTH-1:0] next_result;
        op_request_t exp;
        mod_route_t got_route;
        starts = 0;
        cycle = 0;
        first_start = -1;
        last_start = 0;
        done = 1'b0;
        tick_sent = 1'b0;
        next_result = op_result;
        drive_edge();
        sample_tick = 1'b1;
        while (!done) begin
            @(negedge clk);
            check_flag("sweep_done", sweep_done,
                       first_start >= 0 && cycle == first_start + `NUM_SLOTS * `SLOT_CYCLES);
            done = sweep_done;
            if (op_start) begin
                g = golden[base + starts];
                src = g[32] * `NUM_OPS_PER_BANK + g[28:24];
                exp.slot = slot_of(starts);
                exp.fnum = g[21:12];
                exp.block = g[10:8];
                exp.kon = g[4];
                exp.fb = g[2:0];
                exp.use_feedback = (g[45:44] == ROLE_FEEDBACK);
                exp.modulation = (g[45:44] == ROLE_MODULATED) ? model_out[src] : '0;
                check_request($sformatf("request slot %0d", starts), op_request, exp);
                got_route = dut.route;
                check_flag("route role", got_route.role == op_role_e'(g[45:44]), 1'b1);
                check_flag("route channel", got_route.channel == {g[40], g[39:36]}, 1'b1);
                if (starts == 0) begin
                    first_start = cycle;
                end else begin
                    check_flag("op_start spacing", cycle - last_start == `SLOT_CYCLES, 1'b1);
                end
                last_start = cycle;
                draw_result(next_result);
                model_out[starts] = next_result;
                starts++;
            end
            cycle++;
            drive_edge();
            op_result = next_result;   // valid from the cycle after op_start
            sample_tick = (starts == 10) && !tick_sent;
            tick_sent = tick_sent | sample_tick;
        end
        check_flag("op_start count", starts == `NUM_SLOTS, 1'b1);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == prev_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - prev_errors);
        end
        prev_errors = errors;
    endtask

    initial begin
        int n_golden;
        int base;
        int writes;
        reset = 1'b1;
        sample_tick = 1'b0;
        chan_write = '0;
        conn_sel = '0;
        op_result = '0;
        host_slot = '0;
        lfsr_state = 32'h7f4a;
        model_out = '{default: '0};
        $readmemh("test/operator_slot_controller_golden.txt", golden);
        n_golden = golden[0];
        num_tests = n_golden + 1;

        apply_reset();
        if (n_golden == 0) begin
            errors++;
            $display("golden file is missing or holds no tests");
        end
        repeat (20) begin
            @(negedge clk);
            check_flag("op_start before any tick", op_start, 1'b0);
        end
        read_back();
        finish_test("reset state");

        base = 1;
        for (int t = 0; t < n_golden; t++) begin
            apply_reset();
            writes = golden[base][15:8];
            conn_sel = golden[base][5:0];
            for (int i = 1; i <= writes; i++) begin
                chan_write = write_of(golden[base + i]);
                drive_edge();
            end
            chan_write = '0;
            run_sweep(base + writes + 1);
            read_back();
            finish_test($sformatf("golden sweep %0d", t + 1));
            base += writes + 1 + `NUM_SLOTS;
        end

        if (dut.u_scheduler.u_props.fail_count != 0) begin
            errors += dut.u_scheduler.u_props.fail_count;
            $display("scheduler timing assertions failed %0d times",
                     dut.u_scheduler.u_props.fail_count);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog, sized from the test count once the golden file is read
    initial begin
        wait (num_tests > 0);
        repeat ((num_tests + 1) * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles",
                 (num_tests + 1) * CYCLES_PER_TEST);
        $display("** FAIL **");
        $finish;
    end

endmodule
